/* flist.f */
+incdir+.
cache_pkg.sv
sram.sv
l1_cache_controller.sv
l1_cache.sv
tb_dram_model.sv
tb_l1_cache.sv

/* Makefile */
SRCS = cache_config.svh cache_pkg.sv sram.sv l1_cache_controller.sv l1_cache.sv \
	tb_dram_model.sv tb_l1_cache.sv

obj_dir/Vtb_l1_cache: flist.f $(SRCS)
	verilator --binary --timing --assert -f flist.f --top-module tb_l1_cache \
		--Mdir obj_dir -o Vtb_l1_cache

run: obj_dir/Vtb_l1_cache
	./obj_dir/Vtb_l1_cache | awk '{ print } /^TESTBENCH PASSED$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

.PHONY: run clean

/* tb_l1_cache.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_config.svh"

module tb_l1_cache;

	localparam int ack_timeout = 100;
	localparam int random_ops = 2000;
	localparam logic [`TAG_WIDTH-1:0] tag_base = 22'h2_C3A5;

	logic clk;
	logic rst_i;
	logic [`CACHE_ADDR_WIDTH-1:0] cache_addr;
	logic cache_cs;
	logic cache_we;
	logic [`CPU_DATA_WIDTH-1:0] cache_wdata;
	logic cache_ack;
	logic [`CPU_DATA_WIDTH-1:0] cache_rdata;
	logic [`CACHE_ADDR_WIDTH-1:0] dram_addr;
	logic dram_cs;
	logic dram_we;
	logic dram_ack;
	logic [`MEM_DATA_WIDTH-1:0] dram_rdata;
	logic [`MEM_DATA_WIDTH-1:0] dram_wdata;

	// cpu writes so far keyed by word address
	logic [`CPU_DATA_WIDTH-1:0] shadow [logic [`CACHE_ADDR_WIDTH-1:0]];
	// completed dram accesses in order
	logic dram_log_we [$];
	logic [`CACHE_ADDR_WIDTH-1:0] dram_log_addr [$];

	logic [15:0] lfsr_q = 16'd29295;
	logic ack_prev = 1'b0;
	int checks = 0;
	int errors = 0;
	int timeouts = 0;
	int acks = 0;

	l1_cache UUT (
		.clk (clk),
		.rst_i (rst_i),
		.cache_addr_i (cache_addr),
		.cache_cs_i (cache_cs),
		.cache_we_i (cache_we),
		.cache_data_i (cache_wdata),
		.cache_ack_o (cache_ack),
		.cache_data_o (cache_rdata),
		.dram_addr_o (dram_addr),
		.dram_cs_o (dram_cs),
		.dram_we_o (dram_we),
		.dram_ack_i (dram_ack),
		.dram_data_i (dram_rdata),
		.dram_data_o (dram_wdata)
	);

	tb_dram_model dram_model (
		.clk (clk),
		.rst_i (rst_i),
		.dram_cs_i (dram_cs),
		.dram_we_i (dram_we),
		.dram_addr_i (dram_addr),
		.dram_data_i (dram_wdata),
		.dram_ack_o (dram_ack),
		.dram_data_o (dram_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// galois lfsr stepped once per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr_q[0]};
			lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
		end
		return r;
	endfunction

	function automatic logic [31:0] word_base(input logic [31:0] addr);
		return {addr[31:2], 2'b00};
	endfunction

	function automatic logic [31:0] block_base(input logic [31:0] addr);
		return {addr[31:`OFFSET_WIDTH], {`OFFSET_WIDTH{1'b0}}};
	endfunction

	function automatic logic [31:0] make_addr(input logic [`TAG_WIDTH-1:0] tag,
			input logic [`INDEX_WIDTH-1:0] index, input logic [`WORD_SEL_WIDTH-1:0] word);
		return {tag, index, word, 2'b00};
	endfunction

	// a word is the last cpu write or else the dram fill pattern
	function automatic logic [31:0] expected_word(input logic [31:0] addr);
		logic [31:0] key;
		key = word_base(addr);
		if (shadow.exists(key)) begin
			return shadow[key];
		end
		return (key * 32'h9E37_79B1) ^ 32'h5BD1_E995;
	endfunction

	function automatic logic [`MEM_DATA_WIDTH-1:0] expected_block(input logic [31:0] addr);
		logic [`MEM_DATA_WIDTH-1:0] blk;
		blk = '0;
		for (int w = 0; w < `MEM_DATA_WIDTH / `CPU_DATA_WIDTH; w++) begin
			blk[w * 32 +: 32] = expected_word(block_base(addr) + 32'(w * 4));
		end
		return blk;
	endfunction

	task automatic check(input logic ok, input string msg);
		checks++;
		assert (ok) else begin
			errors++;
			$display("CHECK FAILED at %0t: %s", $time, msg);
		end
	endtask

	task automatic finish_run();
		$display("%0d checks, %0d errors, %0d timeouts, %0d acks", checks, errors, timeouts, acks);
		if (errors == 0 && timeouts == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	endtask

	task automatic apply_reset();
		rst_i <= 1'b1;
		cache_cs <= 1'b0;
		cache_we <= 1'b0;
		cache_addr <= '0;
		cache_wdata <= '0;
		repeat (2) @(posedge clk);
		rst_i <= 1'b0;
		@(negedge clk);
	endtask

	// cycles counts falling edges up to the ack and is 2 for a hit
	task automatic cpu_access(input logic we, input logic [31:0] addr, input logic [31:0] data,
			output int cycles);
		cycles = 0;
		// no new request once one has timed out
		if (timeouts == 0) begin
			@(posedge clk);
			cache_cs <= 1'b1;
			cache_we <= we;
			cache_addr <= addr;
			cache_wdata <= data;
			do begin
				@(negedge clk);
				cycles++;
			end while (!cache_ack && cycles < ack_timeout);
			if (!cache_ack) begin
				$display("timeout: no cache ack within %0d cycles for address %h",
					ack_timeout, addr);
				timeouts++;
			end
			@(posedge clk);
			cache_cs <= 1'b0;
		end
	endtask

	// compares every ack and every dram access
	always @(negedge clk) begin
		if (!rst_i && cache_ack) begin
			acks++;
			check(!ack_prev, "cache ack stayed high for more than one cycle");
			if (cache_we) begin
				shadow[word_base(cache_addr)] = cache_wdata;
			end else begin
				check(cache_rdata == expected_word(cache_addr), $sformatf(
					"read of %h returned %h, expected %h",
					cache_addr, cache_rdata, expected_word(cache_addr)));
			end
		end
		if (!rst_i && dram_cs && dram_ack) begin
			check(dram_addr == block_base(dram_addr),
				$sformatf("dram address %h is not block aligned", dram_addr));
			if (dram_we) begin
				check(dram_wdata == expected_block(dram_addr),
					$sformatf("write back of block %h does not match the cpu writes", dram_addr));
			end
			dram_log_we.push_back(dram_we);
			dram_log_addr.push_back(dram_addr);
		end
		ack_prev = cache_ack;
	end

	initial begin
		int cycles;
		int n;
		logic [31:0] addr_a;
		logic [31:0] addr_b;
		logic [31:0] bits;
		logic [`TAG_WIDTH-1:0] tag;
		logic [`INDEX_WIDTH-1:0] index;
		logic [`WORD_SEL_WIDTH-1:0] word;
		logic we;

		apply_reset();
		check(!cache_ack && !dram_cs && !dram_we, "ack or dram strobes high after reset");

		// cold read fetches its own block
		addr_a = make_addr(22'h0_2A51, 5'd3, 3'd2);
		n = dram_log_addr.size();
		cpu_access(1'b0, addr_a, '0, cycles);
		check(dram_log_addr.size() == n + 1 && !dram_log_we[n]
			&& dram_log_addr[n] == block_base(addr_a), "cold read did not fetch exactly its block");

		// read hit
		n = dram_log_addr.size();
		cpu_access(1'b0, addr_a, '0, cycles);
		check(cycles == 2 && dram_log_addr.size() == n,
			$sformatf("read hit took %0d cycles or reached dram", cycles));

		// write hit followed by reads of the whole block
		cpu_access(1'b1, addr_a, 32'hC0DE_0A11, cycles);
		check(cycles == 2, $sformatf("write hit took %0d cycles", cycles));
		for (int w = 0; w < 8; w++) begin
			cpu_access(1'b0, make_addr(22'h0_2A51, 5'd3, w[2:0]), '0, cycles);
		end

		// conflicting tag evicts the dirty line
		addr_b = make_addr(22'h1_7F0C, 5'd3, 3'd5);
		n = dram_log_addr.size();
		cpu_access(1'b0, addr_b, '0, cycles);
		check(dram_log_addr.size() == n + 2 && dram_log_we[n]
			&& dram_log_addr[n] == block_base(addr_a) && !dram_log_we[n + 1]
			&& dram_log_addr[n + 1] == block_base(addr_b),
			"dirty eviction did not write the victim before fetching the new block");

		// the new line is clean
		n = dram_log_addr.size();
		cpu_access(1'b0, addr_a, '0, cycles);
		check(dram_log_addr.size() == n + 1 && !dram_log_we[n], "clean eviction wrote to dram");

		// four tags over eight lines
		for (int i = 0; i < random_ops; i++) begin
			bits = rand_bits(1);
			we = bits[0];
			bits = rand_bits(2);
			tag = tag_base ^ bits[`TAG_WIDTH-1:0];
			bits = rand_bits(3);
			index = {2'b01, bits[2:0]};
			bits = rand_bits(3);
			word = bits[2:0];
			bits = we ? rand_bits(32) : '0;
			cpu_access(we, make_addr(tag, index, word), bits, cycles);
		end

		finish_run();
	end

endmodule

`default_nettype wire

/* tb_dram_model.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_config.svh"

// behavioral dram with a random ack delay of 1 to 6 cycles
module tb_dram_model #(
	parameter logic [15:0] seed = 16'd29295
) (
	input wire clk,
	input wire rst_i,
	input wire dram_cs_i,
	input wire dram_we_i,
	input wire [`CACHE_ADDR_WIDTH-1:0] dram_addr_i,
	input wire [`MEM_DATA_WIDTH-1:0] dram_data_i,
	output logic dram_ack_o,
	output logic [`MEM_DATA_WIDTH-1:0] dram_data_o
);

	localparam int block_bits = `CACHE_ADDR_WIDTH - `OFFSET_WIDTH;
	localparam int words = `MEM_DATA_WIDTH / `CPU_DATA_WIDTH;

	// holds written blocks while the rest reads as the fill pattern
	logic [`MEM_DATA_WIDTH-1:0] mem [logic [block_bits-1:0]];
	logic [15:0] lfsr_q = seed;
	logic busy_q;
	logic [2:0] wait_q;

	// galois lfsr stepped once per bit
	function automatic logic [15:0] next_bits(input int n);
		logic [15:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[14:0], lfsr_q[0]};
			lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
		end
		return r;
	endfunction

	function automatic logic [`MEM_DATA_WIDTH-1:0] read_block(input logic [block_bits-1:0] blk);
		logic [`MEM_DATA_WIDTH-1:0] data;
		logic [`CACHE_ADDR_WIDTH-1:0] a;
		if (mem.exists(blk)) begin
			return mem[blk];
		end
		data = '0;
		for (int w = 0; w < words; w++) begin
			a = {blk, w[`WORD_SEL_WIDTH-1:0], 2'b00};
			data[w * `CPU_DATA_WIDTH +: `CPU_DATA_WIDTH] = (a * 32'h9E37_79B1) ^ 32'h5BD1_E995;
		end
		return data;
	endfunction

	always @(posedge clk) begin
		if (rst_i) begin
			busy_q <= 1'b0;
			wait_q <= '0;
			dram_ack_o <= 1'b0;
		end else begin
			dram_ack_o <= 1'b0;
			if (busy_q) begin
				if (wait_q == 3'd1) begin
					busy_q <= 1'b0;
					dram_ack_o <= 1'b1;
					if (dram_we_i) begin
						mem[dram_addr_i[`CACHE_ADDR_WIDTH-1:`OFFSET_WIDTH]] = dram_data_i;
					end else begin
						dram_data_o <= read_block(dram_addr_i[`CACHE_ADDR_WIDTH-1:`OFFSET_WIDTH]);
					end
				end else begin
					wait_q <= wait_q - 3'd1;
				end
			end else if (dram_cs_i && !dram_ack_o) begin
				// the cycle after an ack belongs to the old request
				busy_q <= 1'b1;
				wait_q <= 3'(next_bits(3) % 16'd6) + 3'd1;
			end
		end
	end

endmodule

`default_nettype wire

/* l1_cache.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_config.svh"

module l1_cache (
	input wire clk,
	input wire rst_i,

	// cpu side
	input wire [`CACHE_ADDR_WIDTH-1:0] cache_addr_i,
	input wire cache_cs_i,
	input wire cache_we_i,
	input wire [`CPU_DATA_WIDTH-1:0] cache_data_i,
	output logic cache_ack_o,
	output logic [`CPU_DATA_WIDTH-1:0] cache_data_o,

	// dram side
	output logic [`CACHE_ADDR_WIDTH-1:0] dram_addr_o,
	output logic dram_cs_o,
	output logic dram_we_o,
	input wire dram_ack_i,
	input wire [`MEM_DATA_WIDTH-1:0] dram_data_i,
	output logic [`MEM_DATA_WIDTH-1:0] dram_data_o
);

	import cache_pkg::*;

	// request address fields
	logic [`TAG_WIDTH-1:0] addr_tag;
	logic [`INDEX_WIDTH-1:0] addr_index;
	logic [`WORD_SEL_WIDTH-1:0] word_sel;

	// tag storage holds {dirty, tag}
	logic [`TAG_WIDTH:0] tag_rdata;
	logic [`TAG_WIDTH:0] tag_wdata;
	logic [`TAG_WIDTH-1:0] sram_tag;
	logic sram_dirty;

	// block storage
	logic [`MEM_DATA_WIDTH-1:0] block_rdata;
	logic [`MEM_DATA_WIDTH-1:0] block_wdata;
	logic [`MEM_DATA_WIDTH-1:0] merged_block;

	// one valid bit per line
	logic [`CACHE_LINES-1:0] valid_q;
	logic line_valid;

	logic cache_hit;
	logic victim_dirty;

	// controller outputs
	logic tag_we;
	logic data_we;
	logic fill;
	logic dirty;
	dram_addr_sel_e dram_addr_sel;

	assign addr_tag = cache_addr_i[`CACHE_ADDR_WIDTH-1 -: `TAG_WIDTH];
	assign addr_index = cache_addr_i[`OFFSET_WIDTH +: `INDEX_WIDTH];
	// accesses are whole words so byte offset bits 1:0 are ignored
	assign word_sel = cache_addr_i[`OFFSET_WIDTH-1 -: `WORD_SEL_WIDTH];

	assign sram_dirty = tag_rdata[`TAG_WIDTH];
	assign sram_tag = tag_rdata[`TAG_WIDTH-1:0];

	// valid bits are cleared by reset and set by every tag write
	always_ff @(posedge clk) begin
		if (rst_i) begin
			valid_q <= '0;
		end else if (tag_we) begin
			valid_q[addr_index] <= 1'b1;
		end
	end

	assign line_valid = valid_q[addr_index];

	assign cache_hit = line_valid && (sram_tag == addr_tag);

	// an invalid line never needs a write back
	assign victim_dirty = line_valid && sram_dirty;

	// requested word out of the stored block
	assign cache_data_o = block_rdata[word_sel * `CPU_DATA_WIDTH +: `CPU_DATA_WIDTH];

	// cpu word dropped into the stored block
	always_comb begin
		merged_block = block_rdata;
		merged_block[word_sel * `CPU_DATA_WIDTH +: `CPU_DATA_WIDTH] = cache_data_i;
	end

	// refill takes the dram block and a write hit the merged one
	assign block_wdata = fill ? dram_data_i : merged_block;

	assign tag_wdata = {dirty, addr_tag};

	// block aligned dram address
	always_comb begin
		case (dram_addr_sel)
			VICTIM_BLOCK: begin
				dram_addr_o = {sram_tag, addr_index, {`OFFSET_WIDTH{1'b0}}};
			end
			default: begin
				dram_addr_o = {addr_tag, addr_index, {`OFFSET_WIDTH{1'b0}}};
			end
		endcase
	end

	// write back always sends the stored block
	assign dram_data_o = block_rdata;

	l1_cache_controller u_controller (
		.clk (clk),
		.rst_i (rst_i),

		.cache_cs_i (cache_cs_i),
		.cache_we_i (cache_we_i),
		.cache_ack_o (cache_ack_o),

		.cache_hit_i (cache_hit),
		.victim_dirty_i (victim_dirty),

		.tag_we_o (tag_we),
		.data_we_o (data_we),
		.fill_o (fill),
		.dirty_o (dirty),

		.dram_addr_sel_o (dram_addr_sel),
		.dram_cs_o (dram_cs_o),
		.dram_we_o (dram_we_o),
		.dram_ack_i (dram_ack_i)
	);

	sram #(
		.data_width (`TAG_WIDTH + 1),
		.depth (`CACHE_LINES)
	) tag_storage (
		.clk (clk),
		.addr_i (addr_index),
		.we_i (tag_we),
		.data_i (tag_wdata),
		.data_o (tag_rdata)
	);

	sram #(
		.data_width (`MEM_DATA_WIDTH),
		.depth (`CACHE_LINES)
	) data_storage (
		.clk (clk),
		.addr_i (addr_index),
		.we_i (data_we),
		.data_i (block_wdata),
		.data_o (block_rdata)
	);

endmodule

`default_nettype wire

/* l1_cache_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module l1_cache_controller (
	input wire clk,
	input wire rst_i,

	// cpu handshake
	input wire cache_cs_i,
	input wire cache_we_i,
	output logic cache_ack_o,

	// status from the datapath
	input wire cache_hit_i,
	input wire victim_dirty_i,

	// tag and data storage control
	output logic tag_we_o,
	output logic data_we_o,
	output logic fill_o,
	output logic dirty_o,

	// dram handshake
	output cache_pkg::dram_addr_sel_e dram_addr_sel_o,
	output logic dram_cs_o,
	output logic dram_we_o,
	input wire dram_ack_i
);

	import cache_pkg::*;

	cache_state_e state_q;
	cache_state_e state_d;

	// state register
	always_ff @(posedge clk) begin
		if (rst_i) begin
			state_q <= IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// next state
	always_comb begin
		state_d = state_q;

		case (state_q)
			IDLE: begin
				// srams read the request index on this edge
				if (cache_cs_i) begin
					state_d = COMPARE;
				end
			end

			COMPARE: begin
				if (cache_hit_i) begin
					state_d = IDLE;
				end else if (victim_dirty_i) begin
					state_d = WRITE_BACK;
				end else begin
					state_d = ALLOCATE;
				end
			end

			WRITE_BACK: begin
				// victim block leaves before the new one is fetched
				if (dram_ack_i) begin
					state_d = ALLOCATE;
				end
			end

			ALLOCATE: begin
				if (dram_ack_i) begin
					state_d = REFILL;
				end
			end

			REFILL: begin
				// one cycle so the srams return the new line
				state_d = COMPARE;
			end

			default: begin
				state_d = IDLE;
			end
		endcase
	end

	// outputs decoded from state, hit and dram ack
	always_comb begin
		cache_ack_o = 1'b0;
		tag_we_o = 1'b0;
		data_we_o = 1'b0;
		fill_o = 1'b0;
		dirty_o = 1'b0;
		dram_addr_sel_o = MISS_BLOCK;
		dram_cs_o = 1'b0;
		dram_we_o = 1'b0;

		case (state_q)
			COMPARE: begin
				if (cache_hit_i) begin
					cache_ack_o = 1'b1;

					// write hit merges the cpu word and marks the line dirty
					tag_we_o = cache_we_i;
					data_we_o = cache_we_i;
					dirty_o = 1'b1;
				end
			end

			WRITE_BACK: begin
				dram_addr_sel_o = VICTIM_BLOCK;
				dram_cs_o = 1'b1;
				dram_we_o = 1'b1;
			end

			ALLOCATE: begin
				dram_addr_sel_o = MISS_BLOCK;
				dram_cs_o = 1'b1;

				// fresh block goes in clean
				if (dram_ack_i) begin
					tag_we_o = 1'b1;
					data_we_o = 1'b1;
					fill_o = 1'b1;
				end
			end

			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

/* sram.sv */
`timescale 1ns/1ps
`default_nettype none

// single port synchronous ram with read-first behavior
module sram #(
	parameter int data_width = 32,
	parameter int depth = 32
) (
	input wire clk,

	// one address for both read and write
	input wire [$clog2(depth)-1:0] addr_i,
	input wire we_i,
	input wire [data_width-1:0] data_i,
	output logic [data_width-1:0] data_o
);

	logic [data_width-1:0] mem [depth];

	// write port
	always_ff @(posedge clk) begin
		if (we_i) begin
			mem[addr_i] <= data_i;
		end
	end

	// registered read
	// a write on the same edge still returns the old word
	always_ff @(posedge clk) begin
		data_o <= mem[addr_i];
	end

endmodule

`default_nettype wire

/* cache_pkg.sv */
`default_nettype none

package cache_pkg;

	// controller states
	// compare is also the cycle that acks a hit
	typedef enum logic [2:0] {
		IDLE,
		COMPARE,
		WRITE_BACK,
		ALLOCATE,
		REFILL
	} cache_state_e;

	// where the dram block address comes from
	typedef enum logic {
		// stored tag with the current index
		VICTIM_BLOCK,
		// cpu address with its offset cleared
		MISS_BLOCK
	} dram_addr_sel_e;

endpackage

`default_nettype wire

/* cache_config.svh */
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// cpu and dram port widths
`define CACHE_ADDR_WIDTH 32
`define CPU_DATA_WIDTH 32
`define MEM_DATA_WIDTH 256

// address split into tag, index and byte offset
`define TAG_WIDTH 22
`define INDEX_WIDTH 5
`define OFFSET_WIDTH 5

// word select is the upper part of the byte offset
`define WORD_SEL_WIDTH 3

// direct mapped, one block per line
`define CACHE_LINES 32

`endif
